/* bench/program_vectors.txt */
# P <word address> <instruction>   program image, hex
# W <rd> <value>                   expected writeback in program order, hex
P 00 00500093  # addi x1,x0,5
P 01 FFD00113  # addi x2,x0,-3
P 02 002081B3  # add  x3,x1,x2
P 03 40208233  # sub  x4,x1,x2
P 04 00309293  # slli x5,x1,3
P 05 40115313  # srai x6,x2,1
P 06 01C15393  # srli x7,x2,28
P 07 00112433  # slt  x8,x2,x1
P 08 001134B3  # sltu x9,x2,x1
P 09 0020C533  # xor  x10,x1,x2
P 0A 0F00E593  # ori  x11,x1,0xf0
P 0B 12345637  # lui  x12,0x12345
P 0C 00001697  # auipc x13,0x1 at pc 0x30
P 0D 00C02423  # sw   x12,8(x0)
P 0E 00802703  # lw   x14,8(x0)
P 0F 00170793  # addi x15,x14,1 load use
P 10 00108663  # beq  x1,x1,+12 taken
P 11 06300A13  # flushed
P 12 06300A93  # flushed
P 13 00C0086F  # jal  x16,+12 at pc 0x4c
P 14 06300A13  # flushed
P 15 06300A93  # flushed
P 16 00109463  # bne  x1,x1,+8 not taken
P 17 06C00893  # addi x17,x0,0x6c
P 18 00088967  # jalr x18,0(x17) at pc 0x60
P 19 06300A13  # flushed
P 1A 06300A93  # flushed
P 1B 00114463  # blt  x2,x1,+8 taken
P 1C 06300A13  # flushed
P 1D 004189B3  # add  x19,x3,x4
P 1E 00000000  # end of program
W 01 00000005
W 02 FFFFFFFD
W 03 00000002
W 04 00000008
W 05 00000028
W 06 FFFFFFFE
W 07 0000000F
W 08 00000001
W 09 00000000
W 0A FFFFFFF8
W 0B 000000F5
W 0C 12345000
W 0D 00001030
W 0E 12345000
W 0F 12345001
W 10 00000050
W 11 0000006C
W 12 00000064
W 13 0000000A

/* verilog.f */
+incdir+rtl
rtl/cpuPkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/pipelinedCpu.sv
bench/tbClock.sv
bench/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpuTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) rtl/cpu_defs.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(BUILD_DIR)

/* bench/cpuTb.sv */
//////////////////////////////////////////////////////////////////////
// testbench for the five stage RV32I core
// loads a program from the vectors file, checks every retirement and halt
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_defs.svh"

module cpuTb;

  localparam string VECTOR_FILE   = "bench/program_vectors.txt";
  localparam int    RESET_TIMEOUT = 10;   // cycles
  localparam int    WB_TIMEOUT    = 40;   // cycles between two retirements
  localparam int    HALT_TIMEOUT  = 20;
  localparam int    HALT_HOLD     = 5;    // cycles halt must stay up

  logic             clk;
  logic             rstN;
  logic             run;
  cpuPkg::progWrite prog;
  cpuPkg::wbInfo    wb;
  logic             halt;

  logic [31:0]      progAddr [$];   // word address
  logic [31:0]      progData [$];
  cpuPkg::wbInfo    expWb [$];      // expected retirements in program order

  tbClock i_clock (
    .clk  (clk),
    .rstN (rstN)
  );

  pipelinedCpu i_dut (
    .clk  (clk),
    .rstN (rstN),
    .run  (run),
    .prog (prog),
    .wb   (wb),
    .halt (halt)
  );

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic checkWb(input string name, input cpuPkg::wbInfo expected,
                         input cpuPkg::wbInfo actual);
    if (actual !== expected)
    begin
      abortRun($sformatf("[FAIL] %s expected x%0d=%h actual x%0d=%h", name,
                         expected.rd, expected.data, actual.rd, actual.data));
    end
  endtask

  task automatic checkHalt(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      abortRun($sformatf("[FAIL] %s expected halt=%b actual halt=%b", name,
                         expected, actual));
    end
  endtask

  // P lines go to the program image and W lines to the expected writebacks
  task automatic readVectors();
    int               fd;
    int               code;
    logic [7:0]       tag;
    logic [31:0]      first;
    logic [31:0]      second;
    logic [8*160-1:0] restOfLine;
    cpuPkg::wbInfo    entry;
    fd = $fopen(VECTOR_FILE, "r");
    if (fd == 0)
    begin
      abortRun("could not open the vectors file");
    end
    while (!$feof(fd))
    begin
      code = $fscanf(fd, " %c", tag);
      if (code != 1)
        break;
      if (tag == "P" || tag == "W")
      begin
        code = $fscanf(fd, "%h %h", first, second);
        if (code != 2)
          abortRun("malformed line in the vectors file");
        if (tag == "P")
        begin
          progAddr.push_back(first);
          progData.push_back(second);
        end
        else
        begin
          entry.valid = 1'b1;
          entry.rd    = first[`REG_AW-1:0];
          entry.data  = second;
          expWb.push_back(entry);
        end
      end
      else
      begin
        code = $fgets(restOfLine, fd);   // comment text up to the end of the line
      end
    end
    $fclose(fd);
    if (progAddr.size() == 0 || expWb.size() == 0)
      abortRun("the vectors file holds no program or no expected writebacks");
  endtask

  initial
  begin
    int cycles;
    int idx;
    run  = 1'b0;
    prog = '0;
    readVectors();

    cycles = 0;
    while (rstN !== 1'b1)
    begin
      @(posedge clk);
      cycles++;
      if (cycles > RESET_TIMEOUT)
        abortRun("reset was never released");
    end

    // program load while the core is parked
    foreach (progAddr[i])
    begin
      @(posedge clk);
      #1;
      prog = '{en: 1'b1, addr: progAddr[i][cpuPkg::IMEM_AW-1:0], data: progData[i]};
    end
    @(posedge clk);
    #1;
    prog = '0;
    run  = 1'b1;

    // one retirement after another in program order
    for (idx = 0; idx < expWb.size(); idx++)
    begin
      cycles = 0;
      do
      begin
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > WB_TIMEOUT)
          abortRun($sformatf("writeback %0d did not come within %0d cycles",
                             idx, WB_TIMEOUT));
      end while (!wb.valid);
      checkWb($sformatf("writeback %0d", idx), expWb[idx], wb);
    end

    cycles = 0;
    while (!halt)
    begin
      @(posedge clk);
      #1;
      cycles++;
      if (wb.valid)
        abortRun("a writeback came after the last expected one");
      if (cycles > HALT_TIMEOUT)
        abortRun("halt did not rise after the program drained");
    end

    repeat (HALT_HOLD)
    begin
      @(posedge clk);
      #1;
      checkHalt("halt held", 1'b1, halt);
      if (wb.valid)
        abortRun("a writeback came while the core was halted");
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

/* bench/tbClock.sv */
//////////////////////////////////////////////////////////////////////
// testbench clock and reset
// 20 ns clock, rstN held low for the first two cycles
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tbClock (
  output logic clk,
  output logic rstN
);

  localparam int HALF_PERIOD = 10;  // ns

  initial
  begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial
  begin
    rstN = 1'b0;
    repeat (2) @(posedge clk);
    #1 rstN = 1'b1;   // released 1 ns after the edge like all other inputs
  end

endmodule

/* rtl/pipelinedCpu.sv */
//////////////////////////////////////////////////////////////////////
// five stage RV32I core, top level
// wires the stages together and raises halt once drained
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module pipelinedCpu (
  input  logic             clk,
  input  logic             rstN,
  input  logic             run,
  input  cpuPkg::progWrite prog,
  output cpuPkg::wbInfo    wb,
  output logic             halt
);

  cpuPkg::fetchPkt     ifId;
  cpuPkg::decodePkt    idEx;
  cpuPkg::memPkt       exMem;
  cpuPkg::redirectInfo redirect;
  logic                stall;
  logic                done;
  logic                pipeBusy;

  fetchStage i_fetch (
    .clk      (clk),
    .rstN     (rstN),
    .run      (run),
    .prog     (prog),
    .stall    (stall),
    .redirect (redirect),
    .toDecode (ifId),
    .done     (done)
  );

  decodeStage i_decode (
    .clk       (clk),
    .rstN      (rstN),
    .fromFetch (ifId),
    .flush     (redirect.valid),
    .wb        (wb),
    .exDest    (idEx),     // own ID/EX output, for the load-use check
    .toExecute (idEx),
    .stall     (stall)
  );

  executeStage i_execute (
    .clk        (clk),
    .rstN       (rstN),
    .fromDecode (idEx),
    .memFwd     (exMem),
    .wbFwd      (wb),
    .redirect   (redirect),
    .toMemory   (exMem)
  );

  memoryStage i_memory (
    .clk         (clk),
    .rstN        (rstN),
    .fromExecute (exMem),
    .wb          (wb)
  );

  assign pipeBusy = ifId.valid | idEx.valid | exMem.valid | wb.valid;

  // sticky until reset
  always_ff @(posedge clk)
  begin
    if (!rstN)
      halt <= 1'b0;
    else if (done && !pipeBusy)
      halt <= 1'b1;
  end

endmodule

/* rtl/memoryStage.sv */
//////////////////////////////////////////////////////////////////////
// memory stage
// word data memory and the MEM/WB register
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_defs.svh"

module memoryStage (
  input  logic          clk,
  input  logic          rstN,
  input  cpuPkg::memPkt fromExecute,
  output cpuPkg::wbInfo wb
);

  localparam int DMEM_AW = $clog2(`DMEM_WORDS);

  logic [`XLEN-1:0]   dmem [`DMEM_WORDS];
  logic [DMEM_AW-1:0] wordIdx;
  logic [`XLEN-1:0]   loadWord;

  assign wordIdx  = fromExecute.result[DMEM_AW+1:2];  // low two bits ignored
  assign loadWord = dmem[wordIdx];

  always_ff @(posedge clk)
  begin
    if (fromExecute.valid && fromExecute.isStore)
    begin
      dmem[wordIdx] <= fromExecute.storeData;
    end
  end

  // MEM/WB, valid only for instructions that write a register
  always_ff @(posedge clk)
  begin
    wb <= '{valid: fromExecute.valid && fromExecute.regWrite,
            rd:    fromExecute.rd,
            data:  fromExecute.isLoad ? loadWord : fromExecute.result};
    if (!rstN)
    begin
      wb.valid <= 1'b0;
    end
  end

endmodule

/* rtl/executeStage.sv */
//////////////////////////////////////////////////////////////////////
// execute stage
// forwarding, alu, branch resolution and the EX/MEM register
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_defs.svh"

module executeStage (
  input  logic                clk,
  input  logic                rstN,
  input  cpuPkg::decodePkt    fromDecode,
  input  cpuPkg::memPkt       memFwd,
  input  cpuPkg::wbInfo       wbFwd,
  output cpuPkg::redirectInfo redirect,
  output cpuPkg::memPkt       toMemory
);

  logic [`XLEN-1:0] opA;
  logic [`XLEN-1:0] opB;
  logic [`XLEN-1:0] aluB;
  logic [`XLEN-1:0] aluOut;
  logic [`XLEN-1:0] addrSum;
  logic [`XLEN-1:0] result;
  logic [`XLEN-1:0] target;
  logic [4:0]       shamt;
  logic             altOp;
  logic             isBranch;
  logic             isJump;
  logic             condMet;
  logic             writesRd;
  logic             isLoad;
  logic             isStore;

  // newest value wins, EX/MEM over MEM/WB over register file
  function automatic logic [`XLEN-1:0] pickOperand(input logic [`REG_AW-1:0] rs,
                                                   input logic [`XLEN-1:0]   rfVal,
                                                   input cpuPkg::memPkt      exMem,
                                                   input cpuPkg::wbInfo      memWb);
    if (exMem.valid && exMem.regWrite && !exMem.isLoad && exMem.rd == rs)
      return exMem.result;   // a load here has no data yet so the stall covers it
    else if (memWb.valid && memWb.rd == rs)
      return memWb.data;
    else
      return rfVal;
  endfunction

  assign opA = pickOperand(fromDecode.rs1, fromDecode.rs1Data, memFwd, wbFwd);
  assign opB = pickOperand(fromDecode.rs2, fromDecode.rs2Data, memFwd, wbFwd);

  assign aluB  = (fromDecode.opcode == `OP_COMPUTE) ? opB : fromDecode.imm;
  assign shamt = aluB[4:0];
  // bit 30 picks sub or sra for R type but only sra for I type
  assign altOp = fromDecode.alt &&
                 (fromDecode.opcode == `OP_COMPUTE || fromDecode.funct3 == `F3_SR);

  always_comb
  begin
    case (fromDecode.funct3)
      `F3_ADD:  aluOut = altOp ? opA - aluB : opA + aluB;
      `F3_SLL:  aluOut = opA << shamt;
      `F3_SLT:  aluOut = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(aluB)};
      `F3_SLTU: aluOut = {{(`XLEN-1){1'b0}}, opA < aluB};
      `F3_XOR:  aluOut = opA ^ aluB;
      `F3_SR:
      begin
        if (altOp)
          aluOut = $signed(opA) >>> shamt;  // arithmetic shift keeps the sign
        else
          aluOut = opA >> shamt;
      end
      `F3_OR:   aluOut = opA | aluB;
      default:  aluOut = opA & aluB;       // and
    endcase
  end

  assign addrSum = opA + fromDecode.imm;   // load, store and jalr base

  always_comb
  begin
    case (fromDecode.opcode)
      `OP_COMPUTE, `OP_IMM: result = aluOut;
      `OP_LUI:              result = fromDecode.imm;
      `OP_AUIPC:            result = fromDecode.pc + fromDecode.imm;
      `OP_JAL, `OP_JALR:    result = fromDecode.pc + 4;  // link
      default:              result = addrSum;
    endcase
  end

  // branch condition
  always_comb
  begin
    case (fromDecode.funct3)
      `F3_BEQ:  condMet = (opA == opB);
      `F3_BNE:  condMet = (opA != opB);
      `F3_BLT:  condMet = $signed(opA) < $signed(opB);
      `F3_BGE:  condMet = $signed(opA) >= $signed(opB);
      `F3_BLTU: condMet = opA < opB;
      `F3_BGEU: condMet = opA >= opB;
      default:  condMet = 1'b0;   // undefined codes fall through
    endcase
  end

  assign isBranch = (fromDecode.opcode == `OP_BRANCH);
  assign isJump   = (fromDecode.opcode == `OP_JAL) || (fromDecode.opcode == `OP_JALR);
  assign isLoad   = (fromDecode.opcode == `OP_LOAD) && (fromDecode.funct3 == `F3_WORD);
  assign isStore  = (fromDecode.opcode == `OP_STORE) && (fromDecode.funct3 == `F3_WORD);
  assign writesRd = (fromDecode.rd != '0) &&
                    (fromDecode.opcode == `OP_COMPUTE || fromDecode.opcode == `OP_IMM ||
                     fromDecode.opcode == `OP_LUI || fromDecode.opcode == `OP_AUIPC ||
                     isJump || isLoad);

  // predicted not taken so every taken transfer redirects
  assign target   = (fromDecode.opcode == `OP_JALR) ? {addrSum[`XLEN-1:1], 1'b0}
                                                     : fromDecode.pc + fromDecode.imm;
  assign redirect = '{valid:  fromDecode.valid && (isJump || (isBranch && condMet)),
                      target: target};

  always_ff @(posedge clk)
  begin
    toMemory <= '{valid:     fromDecode.valid,
                  regWrite:  fromDecode.valid && writesRd,
                  isLoad:    fromDecode.valid && isLoad,
                  isStore:   fromDecode.valid && isStore,
                  rd:        fromDecode.rd,
                  result:    result,
                  storeData: opB};
    if (!rstN)
    begin
      toMemory.valid <= 1'b0;
    end
  end

  // decode must have dropped its slot on the following cycle
  redirectFlush: assert property (@(posedge clk) disable iff (!rstN)
    redirect.valid |=> !fromDecode.valid);

endmodule

/* rtl/decodeStage.sv */
//////////////////////////////////////////////////////////////////////
// instruction decode
// field split, immediates, register file and load-use check
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_defs.svh"

module decodeStage (
  input  logic             clk,
  input  logic             rstN,
  input  cpuPkg::fetchPkt  fromFetch,
  input  logic             flush,
  input  cpuPkg::wbInfo    wb,
  input  cpuPkg::decodePkt exDest,
  output cpuPkg::decodePkt toExecute,
  output logic             stall
);

  logic [`XLEN-1:0]   regs [2**`REG_AW];  // entry 0 is never written
  logic [31:0]        ir;
  logic [6:0]         opcode;
  logic [`REG_AW-1:0] rs1;
  logic [`REG_AW-1:0] rs2;
  logic [`REG_AW-1:0] rd;
  logic [`XLEN-1:0]   imm;
  logic [`XLEN-1:0]   rs1Val;
  logic [`XLEN-1:0]   rs2Val;
  logic               useRs1;
  logic               useRs2;

  assign ir     = fromFetch.instr;
  assign opcode = ir[6:0];
  assign rd     = ir[11:7];
  assign rs1    = ir[19:15];
  assign rs2    = ir[24:20];

  // immediate per format
  always_comb
  begin
    case (opcode)
      `OP_STORE:            imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      `OP_BRANCH:           imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
      `OP_LUI, `OP_AUIPC:   imm = {ir[31:12], 12'b0};
      `OP_JAL:              imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
      default:              imm = {{20{ir[31]}}, ir[31:20]};  // I type
    endcase
  end

  // register file, write happens before read via the wb bypass
  always_ff @(posedge clk)
  begin
    if (wb.valid && wb.rd != '0)
    begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs1Val = (rs1 == '0) ? '0 :
                  (wb.valid && wb.rd == rs1) ? wb.data : regs[rs1];
  assign rs2Val = (rs2 == '0) ? '0 :
                  (wb.valid && wb.rd == rs2) ? wb.data : regs[rs2];

  // which source fields are real registers
  assign useRs1 = !(opcode == `OP_LUI || opcode == `OP_AUIPC || opcode == `OP_JAL);
  assign useRs2 = (opcode == `OP_COMPUTE) || (opcode == `OP_BRANCH) || (opcode == `OP_STORE);

  // load in execute feeding this instruction, hold one cycle
  assign stall = fromFetch.valid && exDest.valid && (exDest.opcode == `OP_LOAD) &&
                 (exDest.rd != '0) &&
                 ((useRs1 && exDest.rd == rs1) || (useRs2 && exDest.rd == rs2));

  // ID/EX register, a stall or flush sends a bubble
  always_ff @(posedge clk)
  begin
    toExecute <= '{valid:   fromFetch.valid && !stall && !flush,
                   pc:      fromFetch.pc,
                   opcode:  opcode,
                   funct3:  ir[14:12],
                   alt:     ir[30],
                   rs1:     rs1,
                   rs2:     rs2,
                   rd:      rd,
                   rs1Data: rs1Val,
                   rs2Data: rs2Val,
                   imm:     imm};
    if (!rstN)
    begin
      toExecute.valid <= 1'b0;   // payload keeps its value
    end
  end

  // execute and memory must never retire into x0
  noX0Write: assert property (@(posedge clk) disable iff (!rstN)
    wb.valid |-> wb.rd != '0);

endmodule

/* rtl/fetchStage.sv */
//////////////////////////////////////////////////////////////////////
// instruction fetch
// pc, instruction memory with load port, IF/ID register
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "cpu_defs.svh"

module fetchStage (
  input  logic                clk,
  input  logic                rstN,
  input  logic                run,
  input  cpuPkg::progWrite    prog,
  input  logic                stall,
  input  cpuPkg::redirectInfo redirect,
  output cpuPkg::fetchPkt     toDecode,
  output logic                done
);

  logic [`XLEN-1:0] pc;
  logic [31:0]      imem [`IMEM_WORDS];
  logic [31:0]      instr;

  assign instr = imem[pc[cpuPkg::IMEM_AW+1:2]];  // async read, word index

  // program load, only while the core is parked
  always_ff @(posedge clk)
  begin
    if (prog.en && !run)
    begin
      imem[prog.addr] <= prog.data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      pc             <= '0;
      done           <= 1'b0;
      toDecode.valid <= 1'b0;
    end
    else if (redirect.valid)
    begin
      // taken branch or jump, drop the slot being fetched
      pc             <= redirect.target;
      done           <= 1'b0;   // a zero word on the wrong path is not the end
      toDecode.valid <= 1'b0;
    end
    else if (!stall)            // stall holds pc and IF/ID as they are
    begin
      toDecode.valid <= 1'b0;
      if (run && !done)
      begin
        if (instr == '0)
        begin
          done <= 1'b1;         // end of program, stop fetching
        end
        else
        begin
          toDecode <= '{valid: 1'b1, pc: pc, instr: instr};
          pc       <= pc + 4;
        end
      end
    end
  end

  // program image must be stable once the core runs
  progWhileRun: assert property (@(posedge clk) disable iff (!rstN)
    run |-> !prog.en);

endmodule

/* rtl/cpuPkg.sv */
//////////////////////////////////////////////////////////////////////
// pipeline packet types
// packed structs passed between the five stages
//////////////////////////////////////////////////////////////////////
`include "cpu_defs.svh"

package cpuPkg;

  localparam int IMEM_AW = $clog2(`IMEM_WORDS);  // word address bits

  // IF/ID register contents
  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    logic [31:0]       instr;
  } fetchPkt;

  // ID/EX register, immediate already sign extended
  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              alt;       // instruction bit 30
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]  rs1Data;
    logic [`XLEN-1:0]  rs2Data;
    logic [`XLEN-1:0]  imm;
  } decodePkt;

  // EX/MEM register
  typedef struct packed {
    logic              valid;
    logic              regWrite;
    logic              isLoad;
    logic              isStore;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]  result;    // alu value or memory address
    logic [`XLEN-1:0]  storeData;
  } memPkt;

  // MEM/WB register, also the retire port
  typedef struct packed {
    logic              valid;
    logic [`REG_AW-1:0] rd;
    logic [`XLEN-1:0]  data;
  } wbInfo;

  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  target;
  } redirectInfo;

  // program load port into instruction memory
  typedef struct packed {
    logic              en;
    logic [IMEM_AW-1:0] addr;
    logic [31:0]       data;
  } progWrite;

endpackage

/* rtl/cpu_defs.svh */
//////////////////////////////////////////////////////////////////////
// RV32I pipeline constants
// opcodes, funct3 codes, widths and memory depths
//////////////////////////////////////////////////////////////////////
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define XLEN        32   // data and address width
`define REG_AW      5    // 32 architectural registers
`define IMEM_WORDS  256
`define DMEM_WORDS  256

// major opcodes
`define OP_COMPUTE  7'b0110011
`define OP_IMM      7'b0010011
`define OP_BRANCH   7'b1100011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111

// alu funct3, sub and sra are picked by instruction bit 30
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SR       3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// branch conditions
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

`define F3_WORD     3'b010   // lw / sw size code

`endif
